// ==== mem_wb.f ====
+incdir+include
verilog/rv32i_types.sv
verilog/mem_stage.sv
verilog/data_mem.sv
verilog/write_back.sv
verilog/regfile.sv
verilog/mem_wb_top.sv
verification/mem_wb_tb.sv

// ==== Bender.yml ====
package:
  name: mem_wb

sources:
  - include_dirs:
      - include
    files:
      - verilog/rv32i_types.sv
      - verilog/mem_stage.sv
      - verilog/data_mem.sv
      - verilog/write_back.sv
      - verilog/regfile.sv
      - verilog/mem_wb_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/mem_wb_tb.sv

// ==== verification/mem_wb_tb.sv ====
`timescale 1ns/1ps
`include "rv32i_macros.svh"

module mem_wb_tb import rv32i_types::*;
();

    // the tests send about 70 instructions and each drains in well under ten cycles.
    localparam int TIMEOUT_CYCLES = 2000;

    typedef struct packed
    {
        rv32i_reg   rd;
        rv32i_word  data;
        logic       load;
        logic       redirect;
        pcmux_sel_t pcmux;
        rv32i_word  target;
    } wb_expect_t;

    logic            clk;
    logic            rst_n;
    logic            in_valid;
    rv32i_word       pc_plus4;
    rv32i_word       alu_result;
    rv32i_word       store_data;
    rv32i_word       br_en;
    rv32i_word       u_imm;
    rv32i_reg        rd;
    logic            load_regfile;
    regfilemux_sel_t regfilemux_sel;
    pcmux_sel_t      pcmux_sel;
    store_sel_t      store_sel;
    logic            mem_stall;
    logic            credit_return;
    rv32i_reg        rs1;
    rv32i_reg        rs2;
    rv32i_word       rs1_data;
    rv32i_word       rs2_data;
    logic            wb_load_regfile;
    rv32i_reg        wb_rd;
    rv32i_word       wb_rd_data;
    logic            pc_redirect_valid;
    pcmux_sel_t      pcmux_sel_out;
    rv32i_word       alu_out_to_pc;

    wb_expect_t expect_q[$];
    int         credits;
    int         returned;
    int         cycles = 0;

    mem_wb_top i_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic end_with_failure(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic report_mismatch(input string msg);
        end_with_failure($sformatf("FAIL at %0t ns: %s", $time, msg));
    endtask

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
            end_with_failure($sformatf("timeout: run still busy after %0d cycles", cycles));
    end

    // every visible write-back is matched against the oldest outstanding expectation.
    always @(negedge clk)
    begin
        wb_expect_t e;
        if (rst_n)
        begin
            if (credit_return)
            begin
                credits++;
                returned++;
                assert (credits <= `MEM_Q_DEPTH)
                    else end_with_failure("a credit came back that was never spent");
            end
            if (wb_load_regfile || pc_redirect_valid)
            begin
                assert (expect_q.size() > 0)
                    else end_with_failure("write-back seen with no instruction outstanding");
                e = expect_q.pop_front();
                assert (wb_load_regfile == e.load && pc_redirect_valid == e.redirect &&
                        pcmux_sel_out == e.pcmux)
                    else report_mismatch($sformatf("load %b redirect %b pcmux %0d, expected %b %b %0d",
                        wb_load_regfile, pc_redirect_valid, pcmux_sel_out,
                        e.load, e.redirect, e.pcmux));
                if (e.load)
                begin
                    assert (wb_rd == e.rd && wb_rd_data == e.data)
                        else report_mismatch($sformatf("write x%0d = %h, expected x%0d = %h",
                            wb_rd, wb_rd_data, e.rd, e.data));
                end
                if (e.redirect)
                begin
                    assert (alu_out_to_pc == e.target)
                        else report_mismatch($sformatf("redirect target %h, expected %h",
                            alu_out_to_pc, e.target));
                end
            end
        end
    end

    function automatic rv32i_word extract(input rv32i_word w, input int off,
                                          input regfilemux_sel_t sel);
        rv32i_word   s;
        logic [7:0]  b;
        logic [15:0] h;
        s = w >> (8 * off);
        b = s[7:0];
        h = s[15:0];
        case (sel)
            rf_lb:   return {{24{b[7]}}, b};
            rf_lbu:  return {24'h0, b};
            rf_lh:   return {{16{h[15]}}, h};
            rf_lhu:  return {16'h0, h};
            default: return w;
        endcase
    endfunction

    function automatic rv32i_word merge(input rv32i_word old, input rv32i_word d,
                                        input int off, input int nbytes);
        rv32i_word r;
        r = old;
        for (int i = 0; i < nbytes; i++)
            r[(off + i) * 8 +: 8] = d[i * 8 +: 8];
        return r;
    endfunction

    function automatic rv32i_word rand_word_addr();
        return rv32i_word'($urandom_range(0, `DMEM_WORDS - 1)) << 2;
    endfunction

    task automatic expect_wb(input rv32i_reg r, input rv32i_word d, input logic ld,
                             input logic redir, input pcmux_sel_t p, input rv32i_word t);
        expect_q.push_back('{r, d, ld, redir, p, t});
    endtask

    // sends one instruction once a credit is held.
    task automatic send(input rv32i_word alu, input rv32i_word sdata, input store_sel_t ssel,
                        input regfilemux_sel_t rsel, input rv32i_reg rd_idx, input logic ld,
                        input rv32i_word bren, input pcmux_sel_t psel, input rv32i_word pcp4,
                        input rv32i_word uimm);
        while (credits == 0)
        begin
            @(posedge clk);
            #1;
        end
        in_valid       = 1'b1;
        alu_result     = alu;
        store_data     = sdata;
        store_sel      = ssel;
        regfilemux_sel = rsel;
        rd             = rd_idx;
        load_regfile   = ld;
        br_en          = bren;
        pcmux_sel      = psel;
        pc_plus4       = pcp4;
        u_imm          = uimm;
        credits--;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic store_to(input rv32i_word addr, input rv32i_word data, input store_sel_t ssel);
        send(addr, data, ssel, rf_alu_out, 5'd0, 1'b0, '0, pcmux_pc_plus4, '0, '0);
    endtask

    task automatic load_from(input rv32i_word addr, input regfilemux_sel_t rsel,
                             input rv32i_reg r, input rv32i_word exp);
        expect_wb(r, exp, 1'b1, 1'b0, pcmux_pc_plus4, '0);
        send(addr, '0, st_none, rsel, r, 1'b1, '0, pcmux_pc_plus4, '0, '0);
    endtask

    task automatic wait_idle();
        while (expect_q.size() != 0 || credits != `MEM_Q_DEPTH)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_reg(input rv32i_reg idx, input rv32i_word exp);
        rs1 = idx;
        rs2 = idx;
        #1;
        assert (rs1_data == exp && rs2_data == exp)
            else report_mismatch($sformatf("x%0d reads %h/%h, expected %h",
                idx, rs1_data, rs2_data, exp));
        @(posedge clk);
        #1;
    endtask

    task automatic test_reg_writeback();
        rv32i_word a;
        rv32i_word b;
        rv32i_word u;
        rv32i_word p;
        a = $urandom();
        b = $urandom();
        u = $urandom() & 32'hffff_f000;
        p = $urandom() & 32'hffff_fffc;
        expect_wb(5'd1, a, 1'b1, 1'b0, pcmux_pc_plus4, '0);
        send(a, '0, st_none, rf_alu_out, 5'd1, 1'b1, b, pcmux_pc_plus4, p, u);
        expect_wb(5'd2, b, 1'b1, 1'b0, pcmux_pc_plus4, '0);
        send(a, '0, st_none, rf_br_en, 5'd2, 1'b1, b, pcmux_pc_plus4, p, u);
        expect_wb(5'd3, u, 1'b1, 1'b0, pcmux_pc_plus4, '0);
        send(a, '0, st_none, rf_u_imm, 5'd3, 1'b1, b, pcmux_pc_plus4, p, u);
        expect_wb(5'd4, p, 1'b1, 1'b0, pcmux_pc_plus4, '0);
        send(a, '0, st_none, rf_pc_plus4, 5'd4, 1'b1, b, pcmux_pc_plus4, p, u);
        expect_wb(5'd0, a, 1'b1, 1'b0, pcmux_pc_plus4, '0);
        send(a, '0, st_none, rf_alu_out, 5'd0, 1'b1, b, pcmux_pc_plus4, p, u);
        wait_idle();
        check_reg(5'd1, a);
        check_reg(5'd2, b);
        check_reg(5'd3, u);
        check_reg(5'd4, p);
        check_reg(5'd0, '0);
        // rd_data shows up two cycles after the cycle in which the instruction is sent.
        expect_wb(5'd5, u, 1'b1, 1'b0, pcmux_pc_plus4, '0);
        send(u, '0, st_none, rf_alu_out, 5'd5, 1'b1, b, pcmux_pc_plus4, p, u);
        assert (!wb_load_regfile)
            else end_with_failure("write-back appeared one cycle after the send");
        @(posedge clk);
        #1;
        assert (wb_load_regfile && wb_rd == 5'd5)
            else end_with_failure("write-back missing two cycles after the send");
        wait_idle();
        check_reg(5'd5, u);
    endtask

    task automatic test_word_mem();
        rv32i_word addrs[8];
        rv32i_word data[8];
        int        base;
        base = $urandom_range(0, `DMEM_WORDS - 1);
        // a stride of 37 words never repeats within the memory, so the addresses stay distinct.
        for (int i = 0; i < 8; i++)
        begin
            addrs[i] = rv32i_word'((base + 37 * i) % `DMEM_WORDS) << 2;
            data[i]  = $urandom();
            store_to(addrs[i], data[i], sw);
        end
        for (int i = 0; i < 8; i++)
            load_from(addrs[i], rf_lw, rv32i_reg'(5 + i), data[i]);
        wait_idle();
        for (int i = 0; i < 8; i++)
            check_reg(rv32i_reg'(5 + i), data[i]);
    endtask

    task automatic test_subword_loads();
        rv32i_word addr;
        rv32i_word w;
        addr = rand_word_addr();
        // bytes 0 and 3 are negative, the low half is positive and the high half negative.
        w = ($urandom() & 32'h7f7f_7f7f) | 32'h8000_0080;
        store_to(addr, w, sw);
        for (int off = 0; off < 4; off++)
        begin
            load_from(addr + off, rf_lb, 5'd14, extract(w, off, rf_lb));
            load_from(addr + off, rf_lbu, 5'd15, extract(w, off, rf_lbu));
        end
        for (int off = 0; off < 4; off += 2)
        begin
            load_from(addr + off, rf_lh, 5'd16, extract(w, off, rf_lh));
            load_from(addr + off, rf_lhu, 5'd17, extract(w, off, rf_lhu));
        end
        wait_idle();
    endtask

    task automatic test_subword_stores();
        rv32i_word addr;
        rv32i_word base;
        rv32i_word d;
        addr = rand_word_addr();
        for (int off = 0; off < 4; off++)
        begin
            base = $urandom();
            d    = $urandom();
            store_to(addr, base, sw);
            store_to(addr + off, d, sb);
            load_from(addr, rf_lw, 5'd18, merge(base, d, off, 1));
        end
        for (int off = 0; off < 4; off += 2)
        begin
            base = $urandom();
            d    = $urandom();
            store_to(addr, base, sw);
            store_to(addr + off, d, sh);
            load_from(addr, rf_lw, 5'd19, merge(base, d, off, 2));
        end
        wait_idle();
    endtask

    task automatic test_pc_source();
        rv32i_word  alu;
        rv32i_word  br;
        rv32i_word  pc;
        pcmux_sel_t sel;
        for (int i = 0; i < 6; i++)
        begin
            // an odd target makes the cleared low bit of a jalr visible.
            alu = $urandom() | 32'h0000_0001;
            pc  = $urandom() & 32'hffff_fffc;
            br  = ($urandom() & 32'hffff_fffe) | rv32i_word'(i % 2);
            sel = (i < 2) ? pcmux_pc_plus4 : ((i < 4) ? pcmux_alu_out : pcmux_alu_mod2);
            expect_wb(5'd20, pc, 1'b1, br[0] && sel != pcmux_pc_plus4,
                      br[0] ? sel : pcmux_pc_plus4,
                      (sel == pcmux_alu_mod2) ? (alu & 32'hffff_fffe) : alu);
            send(alu, '0, st_none, rf_pc_plus4, 5'd20, 1'b1, br, sel, pc, '0);
        end
        wait_idle();
    endtask

    task automatic test_stall_credits();
        rv32i_word imm[`MEM_Q_DEPTH];
        mem_stall = 1'b1;
        returned  = 0;
        for (int i = 0; i < `MEM_Q_DEPTH; i++)
        begin
            imm[i] = $urandom();
            expect_wb(rv32i_reg'(24 + i), imm[i], 1'b1, 1'b0, pcmux_pc_plus4, '0);
            send('0, '0, st_none, rf_u_imm, rv32i_reg'(24 + i), 1'b1, '0, pcmux_pc_plus4,
                 '0, imm[i]);
        end
        repeat (3)
        begin
            @(posedge clk);
            #1;
        end
        assert (credits == 0 && returned == 0 && expect_q.size() == `MEM_Q_DEPTH)
            else report_mismatch($sformatf("under stall credits %0d returned %0d pending %0d",
                credits, returned, expect_q.size()));
        mem_stall = 1'b0;
        wait_idle();
        for (int i = 0; i < `MEM_Q_DEPTH; i++)
            check_reg(rv32i_reg'(24 + i), imm[i]);
    endtask

    initial
    begin
        void'($urandom(32'h3c36_f472));
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        pc_plus4       = '0;
        alu_result     = '0;
        store_data     = '0;
        br_en          = '0;
        u_imm          = '0;
        rd             = '0;
        load_regfile   = 1'b0;
        regfilemux_sel = rf_alu_out;
        pcmux_sel      = pcmux_pc_plus4;
        store_sel      = st_none;
        mem_stall      = 1'b0;
        rs1            = '0;
        rs2            = '0;
        credits        = `MEM_Q_DEPTH;
        returned       = 0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reg_writeback();
        test_word_mem();
        test_subword_loads();
        test_subword_stores();
        test_pc_source();
        test_stall_credits();
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== verilog/mem_wb_top.sv ====
`timescale 1ns/1ps

module mem_wb_top import rv32i_types::*;
(
    input  logic            clk,
    input  logic            rst_n,

    input  logic            in_valid,
    input  rv32i_word       pc_plus4,
    input  rv32i_word       alu_result,
    input  rv32i_word       store_data,
    input  rv32i_word       br_en,
    input  rv32i_word       u_imm,
    input  rv32i_reg        rd,
    input  logic            load_regfile,
    input  regfilemux_sel_t regfilemux_sel,
    input  pcmux_sel_t      pcmux_sel,
    input  store_sel_t      store_sel,
    input  logic            mem_stall,
    output logic            credit_return,

    input  rv32i_reg        rs1,
    input  rv32i_reg        rs2,
    output rv32i_word       rs1_data,
    output rv32i_word       rs2_data,

    // write-back result, also seen by the forwarding unit.
    output logic            wb_load_regfile,
    output rv32i_reg        wb_rd,
    output rv32i_word       wb_rd_data,

    output logic            pc_redirect_valid,
    output pcmux_sel_t      pcmux_sel_out,
    output rv32i_word       alu_out_to_pc
);

    rv32i_word       dmem_addr;
    rv32i_word       dmem_wdata;
    rv32i_be         dmem_wmask;
    logic            dmem_read;
    rv32i_word       dmem_rdata;

    logic            mw_valid;
    rv32i_word       mw_pc_plus4;
    rv32i_word       mw_alu;
    rv32i_word       mw_br_en;
    rv32i_word       mw_u_imm;
    rv32i_reg        mw_rd;
    logic            mw_load_regfile;
    regfilemux_sel_t mw_regfilemux_sel;
    pcmux_sel_t      mw_pcmux_sel;
    rv32i_be         mw_mem_byte_enable;

    mem_stage i_mem_stage
    (
        .clk                (clk),
        .rst_n              (rst_n),
        .in_valid           (in_valid),
        .pc_plus4           (pc_plus4),
        .alu_result         (alu_result),
        .store_data         (store_data),
        .br_en              (br_en),
        .u_imm              (u_imm),
        .rd                 (rd),
        .load_regfile       (load_regfile),
        .regfilemux_sel     (regfilemux_sel),
        .pcmux_sel          (pcmux_sel),
        .store_sel          (store_sel),
        .mem_stall          (mem_stall),
        .credit_return      (credit_return),
        .dmem_addr          (dmem_addr),
        .dmem_wdata         (dmem_wdata),
        .dmem_wmask         (dmem_wmask),
        .dmem_read          (dmem_read),
        .wb_valid           (mw_valid),
        .wb_pc_plus4        (mw_pc_plus4),
        .wb_alu             (mw_alu),
        .wb_br_en           (mw_br_en),
        .wb_u_imm           (mw_u_imm),
        .wb_rd              (mw_rd),
        .wb_load_regfile    (mw_load_regfile),
        .wb_regfilemux_sel  (mw_regfilemux_sel),
        .wb_pcmux_sel       (mw_pcmux_sel),
        .wb_mem_byte_enable (mw_mem_byte_enable)
    );

    data_mem i_data_mem
    (
        .clk   (clk),
        .addr  (dmem_addr),
        .wdata (dmem_wdata),
        .wmask (dmem_wmask),
        .read  (dmem_read),
        .rdata (dmem_rdata)
    );

    write_back i_write_back
    (
        .wb_valid          (mw_valid),
        .pc_plus4          (mw_pc_plus4),
        .alu_in            (mw_alu),
        .br_en_in          (mw_br_en),
        .u_imm             (mw_u_imm),
        .rd_in             (mw_rd),
        .load_regfile_in   (mw_load_regfile),
        .regfilemux_sel    (mw_regfilemux_sel),
        .pcmux_sel_in      (mw_pcmux_sel),
        .mem_byte_enable   (mw_mem_byte_enable),
        .r_data_in         (dmem_rdata),
        .load_regfile      (wb_load_regfile),
        .rd                (wb_rd),
        .rd_data           (wb_rd_data),
        .pc_redirect_valid (pc_redirect_valid),
        .pcmux_sel         (pcmux_sel_out),
        .alu_out_to_pc     (alu_out_to_pc)
    );

    regfile i_regfile
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (wb_load_regfile),
        .rd       (wb_rd),
        .rd_data  (wb_rd_data),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

endmodule

// ==== verilog/regfile.sv ====
`timescale 1ns/1ps

module regfile import rv32i_types::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      load,
    input  rv32i_reg  rd,
    input  rv32i_word rd_data,
    input  rv32i_reg  rs1,
    input  rv32i_reg  rs2,
    output rv32i_word rs1_data,
    output rv32i_word rs2_data
);

    rv32i_word regs [32];

    // x0 is never written, so it keeps the zero from reset.
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (load && (rd != 5'd0))
        begin
            regs[rd] <= rd_data;
        end
    end

    // no bypass, a same-cycle write shows up on the next cycle.
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

// ==== verilog/write_back.sv ====
`timescale 1ns/1ps
`include "rv32i_macros.svh"

module write_back import rv32i_types::*;
(
    input  logic            wb_valid,
    input  rv32i_word       pc_plus4,
    input  rv32i_word       alu_in,
    input  rv32i_word       br_en_in,
    input  rv32i_word       u_imm,
    input  rv32i_reg        rd_in,
    input  logic            load_regfile_in,
    input  regfilemux_sel_t regfilemux_sel,
    input  pcmux_sel_t      pcmux_sel_in,
    input  rv32i_be         mem_byte_enable,
    input  rv32i_word       r_data_in,

    output logic            load_regfile,
    output rv32i_reg        rd,
    output rv32i_word       rd_data,

    output logic            pc_redirect_valid,
    output pcmux_sel_t      pcmux_sel,
    output rv32i_word       alu_out_to_pc
);

    logic [7:0]  load_byte;
    logic [15:0] load_half;

    assign load_regfile = wb_valid && load_regfile_in;
    assign rd           = rd_in;

    // pick the byte lane named by the byte enable.
    always_comb
    begin
        case (mem_byte_enable)
            4'b0010: load_byte = r_data_in[15:8];
            4'b0100: load_byte = r_data_in[23:16];
            4'b1000: load_byte = r_data_in[31:24];
            default: load_byte = r_data_in[7:0];
        endcase
    end

    always_comb
    begin
        case (mem_byte_enable)
            4'b0110: load_half = r_data_in[23:8];
            4'b1100: load_half = r_data_in[31:16];
            default: load_half = r_data_in[15:0];
        endcase
    end

    always_comb
    begin
        case (regfilemux_sel)
            rf_br_en:    rd_data = br_en_in;
            rf_u_imm:    rd_data = u_imm;
            rf_lw:       rd_data = r_data_in;
            rf_pc_plus4: rd_data = pc_plus4;
            rf_lb:       rd_data = {{24{load_byte[7]}}, load_byte};
            rf_lbu:      rd_data = {24'b0, load_byte};
            rf_lh:       rd_data = {{16{load_half[15]}}, load_half};
            rf_lhu:      rd_data = {16'b0, load_half};
            default:     rd_data = alu_in;
        endcase
    end

    // a taken branch or a jump steers fetch away from pc+4.
    always_comb
    begin
        if (br_en_in[0])
            pcmux_sel = pcmux_sel_in;
        else
            pcmux_sel = pcmux_pc_plus4;
    end

    assign pc_redirect_valid = wb_valid && (pcmux_sel != pcmux_pc_plus4);

    // jalr targets drop the low bit.
    assign alu_out_to_pc = (pcmux_sel_in == pcmux_alu_mod2) ?
                           {alu_in[`RV32I_XLEN-1:1], 1'b0} : alu_in;

endmodule

// ==== verilog/data_mem.sv ====
`timescale 1ns/1ps
`include "rv32i_macros.svh"

module data_mem import rv32i_types::*;
(
    input  logic      clk,
    input  rv32i_word addr,
    input  rv32i_word wdata,
    input  rv32i_be   wmask,
    input  logic      read,
    output rv32i_word rdata
);

    localparam int IDX_W = $clog2(`DMEM_WORDS);

    rv32i_word        mem [`DMEM_WORDS];
    logic [IDX_W-1:0] word_idx;

    // byte address in, word index out.
    assign word_idx = addr[IDX_W+1:2];

    always_ff @(posedge clk)
    begin
        for (int lane = 0; lane < `RV32I_XLEN/8; lane++)
        begin
            if (wmask[lane])
                mem[word_idx][lane*8 +: 8] <= wdata[lane*8 +: 8];
        end
    end

    // read data is held until the next read.
    always_ff @(posedge clk)
    begin
        if (read)
            rdata <= mem[word_idx];
    end

endmodule

// ==== verilog/mem_stage.sv ====
`timescale 1ns/1ps
`include "rv32i_macros.svh"

module mem_stage import rv32i_types::*;
(
    input  logic            clk,
    input  logic            rst_n,

    input  logic            in_valid,
    input  rv32i_word       pc_plus4,
    input  rv32i_word       alu_result,
    input  rv32i_word       store_data,
    input  rv32i_word       br_en,
    input  rv32i_word       u_imm,
    input  rv32i_reg        rd,
    input  logic            load_regfile,
    input  regfilemux_sel_t regfilemux_sel,
    input  pcmux_sel_t      pcmux_sel,
    input  store_sel_t      store_sel,
    input  logic            mem_stall,
    output logic            credit_return,

    output rv32i_word       dmem_addr,
    output rv32i_word       dmem_wdata,
    output rv32i_be         dmem_wmask,
    output logic            dmem_read,

    output logic            wb_valid,
    output rv32i_word       wb_pc_plus4,
    output rv32i_word       wb_alu,
    output rv32i_word       wb_br_en,
    output rv32i_word       wb_u_imm,
    output rv32i_reg        wb_rd,
    output logic            wb_load_regfile,
    output regfilemux_sel_t wb_regfilemux_sel,
    output pcmux_sel_t      wb_pcmux_sel,
    output rv32i_be         wb_mem_byte_enable
);

    localparam int PTR_W = $clog2(`MEM_Q_DEPTH);
    localparam int CNT_W = $clog2(`MEM_Q_DEPTH + 1);

    rv32i_word       q_pc_plus4     [`MEM_Q_DEPTH];
    rv32i_word       q_alu          [`MEM_Q_DEPTH];
    rv32i_word       q_store_data   [`MEM_Q_DEPTH];
    rv32i_word       q_br_en        [`MEM_Q_DEPTH];
    rv32i_word       q_u_imm        [`MEM_Q_DEPTH];
    rv32i_reg        q_rd           [`MEM_Q_DEPTH];
    logic            q_load_regfile [`MEM_Q_DEPTH];
    regfilemux_sel_t q_regfilemux   [`MEM_Q_DEPTH];
    pcmux_sel_t      q_pcmux        [`MEM_Q_DEPTH];
    store_sel_t      q_store_sel    [`MEM_Q_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] q_count;
    logic             pop;
    logic [1:0]       byte_off;
    rv32i_be          store_mask;
    rv32i_be          load_mask;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`MEM_Q_DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    // the head leaves the queue in every cycle the memory port is free.
    assign pop      = (q_count != '0) && !mem_stall;
    assign byte_off = q_alu[rd_ptr][1:0];

    always_comb
    begin
        case (q_store_sel[rd_ptr])
            sb:      store_mask = 4'b0001;
            sh:      store_mask = 4'b0011;
            sw:      store_mask = 4'b1111;
            default: store_mask = 4'b0000;
        endcase
    end

    always_comb
    begin
        case (q_regfilemux[rd_ptr])
            rf_lb, rf_lbu: load_mask = 4'b0001;
            rf_lh, rf_lhu: load_mask = 4'b0011;
            rf_lw:         load_mask = 4'b1111;
            default:       load_mask = 4'b0000;
        endcase
    end

    // memory port is driven straight from the queue head.
    assign dmem_addr  = {q_alu[rd_ptr][`RV32I_XLEN-1:2], 2'b00};
    assign dmem_wdata = q_store_data[rd_ptr] << {byte_off, 3'b000};
    assign dmem_wmask = pop ? rv32i_be'(store_mask << byte_off) : 4'b0000;
    assign dmem_read  = pop && (load_mask != 4'b0000);

    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            q_pc_plus4[wr_ptr]     <= pc_plus4;
            q_alu[wr_ptr]          <= alu_result;
            q_store_data[wr_ptr]   <= store_data;
            q_br_en[wr_ptr]        <= br_en;
            q_u_imm[wr_ptr]        <= u_imm;
            q_rd[wr_ptr]           <= rd;
            q_load_regfile[wr_ptr] <= load_regfile;
            q_regfilemux[wr_ptr]   <= regfilemux_sel;
            q_pcmux[wr_ptr]        <= pcmux_sel;
            q_store_sel[wr_ptr]    <= store_sel;
        end
    end

    // occupancy also counts the credits still held by this stage.
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            q_count       <= '0;
            credit_return <= 1'b0;
        end
        else
        begin
            credit_return <= pop;
            if (in_valid)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({in_valid, pop})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            wb_valid <= 1'b0;
        else
            wb_valid <= pop;
    end

    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            wb_pc_plus4        <= q_pc_plus4[rd_ptr];
            wb_alu             <= q_alu[rd_ptr];
            wb_br_en           <= q_br_en[rd_ptr];
            wb_u_imm           <= q_u_imm[rd_ptr];
            wb_rd              <= q_rd[rd_ptr];
            wb_load_regfile    <= q_load_regfile[rd_ptr];
            wb_regfilemux_sel  <= q_regfilemux[rd_ptr];
            wb_pcmux_sel       <= q_pcmux[rd_ptr];
            wb_mem_byte_enable <= rv32i_be'(load_mask << byte_off);
        end
    end

endmodule

// ==== verilog/rv32i_types.sv ====
`include "rv32i_macros.svh"

package rv32i_types;

    typedef logic [`RV32I_XLEN-1:0]   rv32i_word;
    typedef logic [4:0]               rv32i_reg;
    typedef logic [`RV32I_XLEN/8-1:0] rv32i_be;

    // sources of the register write value.
    // labels carry a prefix so they stay apart from the pcmux labels.
    typedef enum logic [3:0]
    {
        rf_alu_out  = 4'b0000,
        rf_br_en    = 4'b0001,
        rf_u_imm    = 4'b0010,
        rf_lw       = 4'b0011,
        rf_pc_plus4 = 4'b0100,
        rf_lb       = 4'b0101,
        rf_lbu      = 4'b0110,
        rf_lh       = 4'b0111,
        rf_lhu      = 4'b1000
    } regfilemux_sel_t;

    // sources of the next PC.
    typedef enum logic [1:0]
    {
        pcmux_pc_plus4 = 2'b00,
        pcmux_alu_out  = 2'b01,
        pcmux_alu_mod2 = 2'b10
    } pcmux_sel_t;

    // store width, st_none for anything that does not write memory.
    typedef enum logic [1:0]
    {
        st_none = 2'b00,
        sb      = 2'b01,
        sh      = 2'b10,
        sw      = 2'b11
    } store_sel_t;

endpackage

// ==== include/rv32i_macros.svh ====
`ifndef RV32I_MACROS_SVH
`define RV32I_MACROS_SVH

// architectural word width of the RV32I datapath.
`define RV32I_XLEN 32

// entries in the memory-stage instruction queue.
// the execute stage starts out with this many credits.
`define MEM_Q_DEPTH 4

// number of 32-bit words in the on-chip data memory.
`define DMEM_WORDS 256

`endif
